// File: Makefile
# Verilator build and run for the instruction fetch unit

VERILATOR ?= verilator
TOP       ?= tb_ifetch
RTL_TOP   ?= ifetch_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(filter-out tb_%,$(SOURCES))

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
ifetch_pkg.sv
ifetch_prefetch.sv
ifetch_obi_adapter.sv
ifetch_queue.sv
ifetch_top.sv
tb_ifetch_mem.sv
tb_ifetch.sv

// File: ifetch_obi_adapter.sv
// Bus adapter: A channel FSM, parity and checksum, outstanding counter, parity FIFO
`timescale 1ns/100ps

module ifetch_obi_adapter (
  input  logic                    clk,
  input  logic                    rst_n,

  // Transfer request from the prefetcher
  input  logic                    trans_valid_i,
  output logic                    trans_ready_o,
  input  ifetch_pkg::fetch_req_t  trans_i,

  // Response toward the queue, always accepted
  output logic                    resp_valid_o,
  output ifetch_pkg::fetch_resp_t resp_o,

  // Bus side
  output ifetch_pkg::obi_req_t    obi_req_o,
  input  ifetch_pkg::obi_gnt_t    obi_gnt_i,
  input  ifetch_pkg::obi_resp_t   obi_resp_i
);

  import ifetch_pkg::*;

  obi_state_e state_q;
  obi_state_e state_n;

  // Held A channel while waiting for a grant
  obi_req_t   a_req_q;
  achk_t      achk;

  logic       gntpar_err;
  // Sticky over the waiting cycles of one request
  logic       gntpar_err_q;
  logic       rvalidpar_err;

  // Bit 0 stays low so the outstanding count indexes the oldest entry
  logic [FETCH_DEPTH:0] parity_fifo_q;

  cnt_t       out_cnt_q;
  cnt_t       out_cnt_n;
  logic       count_up;
  logic       count_down;

  ////////////////////////////////////////
  // R channel
  ////////////////////////////////////////

  // Passed straight through, zero cycles
  assign resp_valid_o  = obi_resp_i.rvalid;
  assign resp_o.rdata  = obi_resp_i.rdata;
  assign resp_o.err    = obi_resp_i.err;

  // rvalidpar must be low while rvalid is high
  assign rvalidpar_err = obi_resp_i.rvalid && obi_resp_i.rvalidpar;

  // Grant fault of the oldest transfer joins the response check
  assign resp_o.parity_err = rvalidpar_err || parity_fifo_q[out_cnt_q];

  ////////////////////////////////////////
  // Address checksum
  ////////////////////////////////////////

  // Odd parity of each address byte, bits 1:0 taken as zero
  always_comb begin
    achk[3] = ~^trans_i.addr[31:24];
    achk[2] = ~^trans_i.addr[23:16];
    achk[1] = ~^trans_i.addr[15:8];
    achk[0] = ~^{trans_i.addr[7:2], 2'b00};
  end

  ////////////////////////////////////////
  // A channel FSM
  ////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    case (state_q)
      TRANSPARENT: begin
        // Not granted at once, so hold the channel from registers
        if (obi_req_o.req && !obi_gnt_i.gnt) begin
          state_n = REGISTERED;
        end
      end
      REGISTERED: begin
        if (obi_gnt_i.gnt) begin
          state_n = TRANSPARENT;
        end
      end
      default: state_n = TRANSPARENT;
    endcase
  end

  always_comb begin
    if (state_q == REGISTERED) begin
      // Request is never withdrawn before its grant
      obi_req_o     = a_req_q;
      obi_req_o.req = 1'b1;
    end else begin
      // No limit on outstanding transfers here, credits do that upstream
      obi_req_o      = OBI_REQ_RESET_VAL;
      obi_req_o.req  = trans_valid_i;
      obi_req_o.addr = trans_i.addr;
      obi_req_o.achk = achk;
    end
    obi_req_o.reqpar = !obi_req_o.req;
  end

  // New transfers only once the last one was granted
  assign trans_ready_o = (state_q == TRANSPARENT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TRANSPARENT;
      a_req_q <= OBI_REQ_RESET_VAL;
    end else begin
      state_q <= state_n;
      // Capture on entry to REGISTERED
      if ((state_q == TRANSPARENT) && (state_n == REGISTERED)) begin
        a_req_q <= obi_req_o;
      end
    end
  end

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  assign count_up   = obi_req_o.req && obi_gnt_i.gnt;
  assign count_down = obi_resp_i.rvalid;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   out_cnt_n = out_cnt_q + cnt_t'(1);
      2'b01:   out_cnt_n = out_cnt_q - cnt_t'(1);
      default: out_cnt_n = out_cnt_q;
    endcase
  end

  ////////////////////////////////////////
  // Grant parity tracking
  ////////////////////////////////////////

  // gntpar should be the inverse of gnt during the address phase
  assign gntpar_err = obi_req_o.req && (obi_gnt_i.gnt == obi_gnt_i.gntpar);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q     <= '0;
      gntpar_err_q  <= 1'b0;
      parity_fifo_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      if (obi_req_o.req) begin
        // Accumulate while waiting, clear for the next request on grant
        gntpar_err_q <= obi_gnt_i.gnt ? 1'b0 : (gntpar_err_q || gntpar_err);
      end
      if (count_up) begin
        // Newest at bit 1, oldest at the outstanding count
        parity_fifo_q <= {parity_fifo_q[FETCH_DEPTH-1:1], gntpar_err || gntpar_err_q, 1'b0};
      end
    end
  end

endmodule

// File: ifetch_pkg.sv
// Fetch widths, bus and instruction structs, adapter state enum and queue depth
package ifetch_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Queue slots, and so the number of fetch credits
  localparam int FETCH_DEPTH = 4;

  // Wide enough for 0 to FETCH_DEPTH
  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

  // Queue slot index, FETCH_DEPTH is a power of two so pointers wrap
  localparam int PTR_W = $clog2(FETCH_DEPTH);

  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // One checksum bit per address byte
  localparam int ACHK_W = ADDR_W / 8;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // Byte address, bits 1:0 always zero
  typedef logic [ADDR_W-1:0] addr_t;
  // Instruction word
  typedef logic [WORD_W-1:0] word_t;
  // Address checksum, odd parity per byte
  typedef logic [ACHK_W-1:0] achk_t;
  // Credits, in-flight and outstanding counts
  typedef logic [CNT_W-1:0]  cnt_t;
  // Queue slot pointer
  typedef logic [PTR_W-1:0]  ptr_t;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Prefetcher to adapter
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // A channel toward memory
  typedef struct packed {
    logic  req;
    logic  reqpar;
    addr_t addr;
    achk_t achk;
  } obi_req_t;

  // Grant with its parity
  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_gnt_t;

  // R channel from memory
  typedef struct packed {
    logic  rvalid;
    logic  rvalidpar;
    word_t rdata;
    logic  err;
  } obi_resp_t;

  // Adapter to queue
  typedef struct packed {
    word_t rdata;
    logic  err;
    logic  parity_err;
  } fetch_resp_t;

  // Queue to consumer
  typedef struct packed {
    word_t word;
    addr_t addr;
    logic  err;
    logic  parity_err;
  } instr_t;

  // A channel handling in the adapter
  typedef enum logic {
    TRANSPARENT,
    REGISTERED
  } obi_state_e;

  // Idle A channel
  localparam obi_req_t OBI_REQ_RESET_VAL = '0;

endpackage

// File: ifetch_prefetch.sv
// Prefetcher: program counter, credit counter and sequential request generator
`timescale 1ns/100ps

module ifetch_prefetch (
  input  logic                   clk,
  input  logic                   rst_n,

  // Branch redirect
  input  logic                   branch_i,
  input  ifetch_pkg::addr_t      branch_addr_i,

  // Freed queue slots, as a count
  input  logic [1:0]             credit_return_i,

  // Request toward the adapter
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output ifetch_pkg::fetch_req_t trans_o
);

  import ifetch_pkg::*;

  addr_t pc_q;
  addr_t pc_n;
  cnt_t  credit_q;
  cnt_t  credit_n;
  logic  accept;

  ////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////

  // Need a credit; stay quiet while a branch redirects the counter
  assign trans_valid_o = (credit_q != '0) && !branch_i;
  assign trans_o.addr  = pc_q;

  // Transfer taken by the adapter
  assign accept = trans_valid_o && trans_ready_i;

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  always_comb begin
    pc_n = pc_q;
    if (branch_i) begin
      // Word aligned target, low bits forced to zero
      pc_n = {branch_addr_i[ADDR_W-1:2], 2'b00};
    end else if (accept) begin
      pc_n = pc_q + addr_t'(4);
    end
  end

  ////////////////////////////////////////
  // Credits
  ////////////////////////////////////////

  // One credit per queue slot, one spent per accepted request
  // Returned credits arrive from the queue as they are freed
  always_comb begin
    credit_n = credit_q + cnt_t'(credit_return_i);
    if (accept) begin
      credit_n = credit_n - cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q     <= '0;
      // Start with every slot free
      credit_q <= cnt_t'(FETCH_DEPTH);
    end else begin
      pc_q     <= pc_n;
      credit_q <= credit_n;
    end
  end

endmodule

// File: ifetch_queue.sv
// Fetch queue: word buffer with request addresses, branch flush, discard and credit return
`timescale 1ns/100ps

module ifetch_queue (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    branch_i,

  // Observed prefetcher to adapter handshake
  input  logic                    trans_valid_i,
  input  logic                    trans_ready_i,
  input  ifetch_pkg::fetch_req_t  trans_i,

  // Responses from the adapter, no back-pressure
  input  logic                    resp_valid_i,
  input  ifetch_pkg::fetch_resp_t resp_i,

  // Freed slots as a count, up to two per cycle
  output logic [1:0]              credit_return_o,

  // Consumer side
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output ifetch_pkg::instr_t      instr_o
);

  import ifetch_pkg::*;

  // Address written on request, data written on response
  addr_t       addr_mem [FETCH_DEPTH];
  fetch_resp_t data_mem [FETCH_DEPTH];

  ptr_t req_ptr_q;
  ptr_t resp_ptr_q;
  ptr_t rd_ptr_q;

  cnt_t count_q;
  cnt_t inflight_q;
  cnt_t discard_q;
  // Credits freed but not yet handed back
  cnt_t backlog_q;
  cnt_t freed;

  logic accept;
  logic drop;
  logic write;
  logic pop;

  assign accept = trans_valid_i && trans_ready_i;

  // Stale response, either on the branch itself or while discarding
  assign drop   = resp_valid_i && (branch_i || (discard_q != '0));
  assign write  = resp_valid_i && !drop;

  // Nothing is handed over in a branch cycle, the head gets flushed
  assign instr_valid_o = (count_q != '0) && !branch_i;
  assign pop           = instr_valid_o && instr_ready_i;

  assign instr_o.word       = data_mem[rd_ptr_q].rdata;
  assign instr_o.err        = data_mem[rd_ptr_q].err;
  assign instr_o.parity_err = data_mem[rd_ptr_q].parity_err;
  assign instr_o.addr       = addr_mem[rd_ptr_q];

  ////////////////////////////////////////
  // Credit return
  ////////////////////////////////////////

  // A flush frees every stored slot at once, returned two at a time
  always_comb begin
    freed = backlog_q + cnt_t'(pop) + cnt_t'(drop);
    if (branch_i) begin
      freed = freed + count_q;
    end
  end

  assign credit_return_o = (freed > cnt_t'(2)) ? 2'd2 : freed[1:0];

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_mem[req_ptr_q] <= trans_i.addr;
    end
    if (write) begin
      data_mem[resp_ptr_q] <= resp_i;
    end
  end

  ////////////////////////////////////////
  // Pointers and counts
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_ptr_q  <= '0;
      resp_ptr_q <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      inflight_q <= '0;
      discard_q  <= '0;
      backlog_q  <= '0;
    end else begin
      backlog_q  <= freed - cnt_t'(credit_return_o);
      inflight_q <= inflight_q + cnt_t'(accept) - cnt_t'(resp_valid_i);
      if (accept) begin
        req_ptr_q <= req_ptr_q + ptr_t'(1);
      end
      if (branch_i) begin
        // Skip the slots of words and responses now stale
        rd_ptr_q   <= req_ptr_q;
        resp_ptr_q <= req_ptr_q;
        count_q    <= '0;
        // Everything still on the bus, less the one dropped now
        discard_q  <= inflight_q - cnt_t'(resp_valid_i);
      end else begin
        if (write) begin
          resp_ptr_q <= resp_ptr_q + ptr_t'(1);
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
        count_q <= count_q + cnt_t'(write) - cnt_t'(pop);
        if (drop) begin
          discard_q <= discard_q - cnt_t'(1);
        end
      end
    end
  end

endmodule

// File: ifetch_top.sv
// Fetch unit top: prefetcher, bus adapter and fetch queue
`timescale 1ns/100ps

module ifetch_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // Branch redirect
  input  logic                  branch_i,
  input  ifetch_pkg::addr_t     branch_addr_i,

  // Consumer
  output logic                  instr_valid_o,
  input  logic                  instr_ready_i,
  output ifetch_pkg::instr_t    instr_o,

  // Instruction bus
  output ifetch_pkg::obi_req_t  obi_req_o,
  input  ifetch_pkg::obi_gnt_t  obi_gnt_i,
  input  ifetch_pkg::obi_resp_t obi_resp_i
);

  import ifetch_pkg::*;

  logic        trans_valid;
  logic        trans_ready;
  fetch_req_t  trans;
  logic        resp_valid;
  fetch_resp_t resp;
  logic [1:0]  credit_return;

  // Address and credit source
  ifetch_prefetch i_prefetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .credit_return_i (credit_return),
    .trans_valid_o   (trans_valid),
    .trans_ready_i   (trans_ready),
    .trans_o         (trans)
  );

  // Bus side
  ifetch_obi_adapter i_obi_adapter (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_i       (trans),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_resp_i    (obi_resp_i)
  );

  // Holds words until the consumer takes them
  ifetch_queue i_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .trans_valid_i   (trans_valid),
    .trans_ready_i   (trans_ready),
    .trans_i         (trans),
    .resp_valid_i    (resp_valid),
    .resp_i          (resp),
    .credit_return_o (credit_return),
    .instr_valid_o   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .instr_o         (instr_o)
  );

endmodule

// File: tb_ifetch.sv
// Testbench top with clock, reset, LFSR stimulus, reference model, fetch tests and watchdog
`timescale 1ns/100ps

module tb_ifetch;

  import ifetch_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam logic [31:0] LFSR_SEED   = 32'h800b8b0c;
  // Taps of x^32 + x^22 + x^2 + x + 1 in right shifting form
  localparam logic [31:0] LFSR_TAPS   = 32'h80200003;
  localparam word_t       DATA_KEY    = 32'h5a5a0000;
  // Words consumed over all tests, then a cycle allowance per word
  localparam int          TOTAL_WORDS = 60 + 6 * 12 + 96 + 60 + 20;
  localparam int          BUDGET      = TOTAL_WORDS * 24 + 400;

  logic      clk;
  logic      rst_n;
  logic      branch;
  addr_t     branch_addr;
  logic      instr_valid;
  instr_t    instr;
  obi_req_t  obi_req;
  obi_gnt_t  obi_gnt;
  obi_resp_t obi_resp;

  // Driven once per cycle by the stimulus process
  logic        instr_ready = 1'b0;
  logic        gnt_en      = 1'b0;
  logic        rsp_en      = 1'b0;
  logic        gnt_fault   = 1'b0;
  logic        rsp_fault   = 1'b0;
  // Test controls
  logic        stall       = 1'b0;
  logic        fault_en    = 1'b0;
  logic [31:0] lfsr        = LFSR_SEED;
  // Model state and counts
  addr_t       exp_pc      = '0;
  int          delivered   = 0;
  int          err_words   = 0;
  int          par_words   = 0;
  int          checks      = 0;
  int          errors      = 0;

  ifetch_top i_ifetch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_o       (instr),
    .obi_req_o     (obi_req),
    .obi_gnt_i     (obi_gnt),
    .obi_resp_i    (obi_resp)
  );

  tb_ifetch_mem i_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .obi_req_i   (obi_req),
    .obi_gnt_o   (obi_gnt),
    .obi_resp_o  (obi_resp),
    .gnt_en_i    (gnt_en),
    .rsp_en_i    (rsp_en),
    .gnt_fault_i (gnt_fault),
    .rsp_fault_i (rsp_fault)
  );

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic in_err_window(input addr_t a);
    return (a >= 32'h0000_1000) && (a <= 32'h0000_10ff);
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s done, %0d errors", name, errors - errors_before);
  endtask

  task automatic wait_words(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) begin
      @(negedge clk);
    end
  endtask

  // One cycle branch pulse
  task automatic redirect(input addr_t target);
    @(posedge clk);
    #2;
    branch      = 1'b1;
    branch_addr = target;
    @(posedge clk);
    #2;
    branch = 1'b0;
  endtask

  // No request and nothing outstanding for a few cycles
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clk);
      if (!obi_req.req && (i_mem.outstanding == 0)) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////

  // Consumer ready and memory choices 2 ns after each edge
  always @(posedge clk) begin
    #2;
    instr_ready = stall ? 1'b0 : (take_bits(2) != 0);
    gnt_en      = (take_bits(2) != 0);
    rsp_en      = (take_bits(2) != 0);
    if (fault_en) begin
      gnt_fault = (take_bits(3) == 0);
      rsp_fault = (take_bits(3) == 0);
    end else begin
      gnt_fault = 1'b0;
      rsp_fault = 1'b0;
    end
  end

  // Next expected address restarts on a branch
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc = '0;
    end else if (branch) begin
      exp_pc = {branch_addr[31:2], 2'b00};
    end else if (instr_valid && instr_ready) begin
      check_value(instr.addr, exp_pc, "word address");
      check_value(instr.word, exp_pc ^ DATA_KEY, "instruction word");
      check_value(32'(instr.err), 32'(in_err_window(exp_pc)), "bus error flag");
      check_value(32'(instr.parity_err), 32'(i_mem.par_rec[exp_pc[12:2]]), "parity flag");
      if (instr.err) begin
        err_words++;
      end
      if (instr.parity_err) begin
        par_words++;
      end
      exp_pc = exp_pc + 4;
      delivered++;
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    int          e0;
    int          dly;
    int          base;
    logic [31:0] rnd;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Plain sequential stream from address 0
    e0 = errors;
    wait_words(60);
    report_test("sequential stream", e0);

    // Random targets at random moments
    e0 = errors;
    repeat (6) begin
      @(negedge clk);
      rnd = take_bits(14);
      dly = int'(rnd[13:11]);
      repeat (dly) @(negedge clk);
      redirect(addr_t'({rnd[10:0], 2'b00}));
      wait_words(12);
    end
    report_test("branch", e0);

    // Stream across the whole error window with 64 words inside it
    e0 = errors;
    redirect(32'h0000_0fc0);
    base = err_words;
    wait_words(96);
    check_value(err_words - base, 64, "words flagged with err");
    report_test("bus error", e0);

    e0   = errors;
    base = par_words;
    @(negedge clk);
    fault_en = 1'b1;
    redirect(32'h0000_0400);
    wait_words(60);
    @(negedge clk);
    fault_en = 1'b0;
    check_value(32'(par_words > base), 1, "parity faults reaching the consumer");
    report_test("parity", e0);

    // Fill the queue and idle the bus before a branch frees every slot
    e0 = errors;
    @(negedge clk);
    stall = 1'b1;
    wait_quiet();
    base = i_mem.grant_cnt;
    redirect(32'h0000_1800);
    wait_quiet();
    check_value(i_mem.grant_cnt - base, FETCH_DEPTH, "grants while the consumer stalls");
    stall = 1'b0;
    wait_words(20);
    check_value(i_mem.proto_errs, 0, "bus protocol violations");
    report_test("bus protocol", e0);

    $display("%0d checks, %0d errors, %0d words", checks, errors, delivered);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(BUDGET * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the fetch unit stopped delivering", BUDGET);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tb_ifetch_mem.sv
// Bus memory model: random grant and response delays, error window, parity faults, request records
`timescale 1ns/100ps

module tb_ifetch_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ifetch_pkg::obi_req_t  obi_req_i,
  output ifetch_pkg::obi_gnt_t  obi_gnt_o,
  output ifetch_pkg::obi_resp_t obi_resp_o,

  // Per cycle choices from the testbench, taken on the clock edge
  input  logic                  gnt_en_i,
  input  logic                  rsp_en_i,
  input  logic                  gnt_fault_i,
  input  logic                  rsp_fault_i
);

  import ifetch_pkg::*;

  localparam word_t DATA_KEY = 32'h5a5a0000;

  // Granted transfers in request order, with the grant parity fault of each
  addr_t pend_addr[$];
  logic  pend_fault[$];
  // Expected parity_err per word index, written as the response goes out
  logic  par_rec [2048];
  int    grant_cnt   = 0;
  int    proto_errs  = 0;
  int    outstanding = 0;
  // Request waiting for its grant
  logic  wait_fault  = 1'b0;
  logic  held        = 1'b0;
  addr_t held_addr   = '0;

  // Odd parity of each address byte, bits 1:0 as zero
  function automatic achk_t byte_parity(input addr_t a);
    achk_t c;
    addr_t w;
    w = {a[31:2], 2'b00};
    for (int i = 0; i < ACHK_W; i++) begin
      c[i] = ~^w[8*i +: 8];
    end
    return c;
  endfunction

  function automatic logic in_err_window(input addr_t a);
    return (a >= 32'h0000_1000) && (a <= 32'h0000_10ff);
  endfunction

  task automatic protocol_error(input string msg);
    proto_errs++;
    $display("Bus protocol error at %0t: %s", $time, msg);
  endtask

  initial begin
    obi_gnt_o            = '0;
    obi_gnt_o.gntpar     = 1'b1;
    obi_resp_o           = '0;
    obi_resp_o.rvalidpar = 1'b1;
  end

  ////////////////////////////////////////
  // Bus cycle
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic  gnt_en;
    logic  rsp_en;
    logic  gnt_fault;
    logic  rsp_fault;
    logic  fault;
    addr_t a;
    gnt_en    = gnt_en_i;
    rsp_en    = rsp_en_i;
    gnt_fault = gnt_fault_i;
    rsp_fault = rsp_fault_i;
    if (!rst_n) begin
      pend_addr.delete();
      pend_fault.delete();
      wait_fault = 1'b0;
      held       = 1'b0;
      gnt_en     = 1'b0;
      rsp_en     = 1'b0;
      gnt_fault  = 1'b0;
    end else begin
      // Response seen by the DUT at this edge
      if (obi_resp_o.rvalid) begin
        void'(pend_addr.pop_front());
        void'(pend_fault.pop_front());
      end
      if (obi_req_i.reqpar != !obi_req_i.req) begin
        protocol_error("reqpar is not the inverse of req");
      end
      if (obi_req_i.req) begin
        a = obi_req_i.addr;
        if (obi_req_i.achk != byte_parity(a)) begin
          protocol_error("achk does not match the address");
        end
        if (a[1:0] != 2'b00) begin
          protocol_error("address is not word aligned");
        end
        if (held && (a != held_addr)) begin
          protocol_error("addr changed before the grant");
        end
        // Faulty gntpar in any waiting cycle, the grant cycle included
        fault = wait_fault || (obi_gnt_o.gntpar == obi_gnt_o.gnt);
        if (obi_gnt_o.gnt) begin
          pend_addr.push_back(a);
          pend_fault.push_back(fault);
          grant_cnt++;
          wait_fault = 1'b0;
          held       = 1'b0;
        end else begin
          wait_fault = fault;
          held       = 1'b1;
          held_addr  = a;
        end
      end else if (held) begin
        protocol_error("req dropped before the grant");
      end
      outstanding = pend_addr.size();
      if (outstanding > FETCH_DEPTH) begin
        protocol_error("more transfers outstanding than queue slots");
      end
    end

    #2;
    obi_gnt_o.gnt    = gnt_en;
    obi_gnt_o.gntpar = !gnt_en ^ gnt_fault;
    // Oldest granted transfer answers; it was granted at least one edge ago
    if (rsp_en && (pend_addr.size() != 0)) begin
      a                    = pend_addr[0];
      obi_resp_o.rvalid    = 1'b1;
      obi_resp_o.rvalidpar = rsp_fault;
      obi_resp_o.rdata     = a ^ DATA_KEY;
      obi_resp_o.err       = in_err_window(a);
      par_rec[a[12:2]]     = pend_fault[0] || rsp_fault;
    end else begin
      obi_resp_o           = '0;
      obi_resp_o.rvalidpar = 1'b1;
    end
  end

endmodule
